/* hdl/trig_loop_pkg.sv */
package trig_loop_pkg;

    typedef enum logic [1:0] {
        LS_RESET = 2'd0,
        LS_RUN   = 2'd1,
        LS_STOP  = 2'd2,
        LS_PAUSE = 2'd3
    } loop_state_e;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_INIT,
        CMD_SWEEP,
        CMD_UPDATE
    } loop_cmd_e;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_INIT_WRITE,
        OP_START_COUNT,
        OP_WAIT_COUNT,
        OP_READ_SCALER,
        OP_WRITE_THRESH,
        OP_UPDATE_READ,
        OP_UPDATE_WRITE
    } servo_op_e;

    localparam int WB_ADR_W = 22;
    localparam int WB_DAT_W = 32;
    localparam int THRESH_W = 18;

    localparam logic [WB_ADR_W-1:0] COUNT_CTRL_ADR = 22'h000000; // Bit 0 starts a count.
    localparam logic [WB_ADR_W-1:0] SCAL_BASE      = 22'h000100;
    localparam logic [WB_ADR_W-1:0] THRESH_BASE    = 22'h000200;

    localparam logic [THRESH_W-1:0] DEFAULT_THRESH = 18'd1000;
    localparam logic [THRESH_W-1:0] THRESH_MAX     = '1;

endpackage

/* hdl/loop_state_decode.sv */
`timescale 1ns/10ps

module loop_state_decode
    import trig_loop_pkg::*;
#(
    parameter int NUM_CHAN = 64,
    localparam int IDX_W = $clog2(NUM_CHAN)
) (
    input  logic                wb_clk,
    input  logic                rst_n_i,
    input  logic                loop_enable_i,
    input  logic [1:0]          loop_state_req_i,
    input  logic                thresh_wr_i,
    input  logic                thresh_upd_i,
    input  logic [IDX_W-1:0]    thresh_idx_i,
    input  logic [THRESH_W-1:0] thresh_dat_i,
    input  logic                cmd_done_i,
    output loop_state_e         loop_state_o,
    output logic                reset_complete_o,
    output logic                thresh_ack_o,
    output loop_cmd_e           cmd_o,
    output logic                cmd_start_o,
    output logic                pend_we_o,
    output logic [IDX_W-1:0]    pend_idx_o,
    output logic [THRESH_W-1:0] pend_dat_o
);

    loop_state_e state;
    logic        busy;       // A command is running in the sequencer.
    logic        wr_armed;
    logic        upd_armed;
    logic        quit;
    logic        held;
    logic        wr_accept;
    logic        upd_accept;

    assign quit = !loop_enable_i || loop_state_req_i == LS_RESET;
    assign held = state == LS_STOP || state == LS_PAUSE;
    assign wr_accept = thresh_wr_i && wr_armed && !busy && held;
    assign upd_accept = thresh_upd_i && upd_armed && !busy && state == LS_STOP && !quit;

    assign pend_we_o = wr_accept;
    assign pend_idx_o = thresh_idx_i;
    assign pend_dat_o = thresh_dat_i;
    assign loop_state_o = state;

    always_ff @(posedge wb_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= LS_RESET;
            reset_complete_o <= 1'b0;
            thresh_ack_o <= 1'b0;
            cmd_o <= CMD_NONE;
            cmd_start_o <= 1'b0;
            busy <= 1'b0;
            wr_armed <= 1'b0;
            upd_armed <= 1'b0;
        end else begin
            cmd_start_o <= 1'b0;
            thresh_ack_o <= wr_accept || (cmd_done_i && cmd_o == CMD_UPDATE);
            if (!thresh_wr_i) begin
                wr_armed <= 1'b1;                // Line seen low, so it may be taken again.
            end else if (wr_accept) begin
                wr_armed <= 1'b0;
            end
            if (!thresh_upd_i) begin
                upd_armed <= 1'b1;
            end else if (upd_accept) begin
                upd_armed <= 1'b0;
            end
            if (cmd_done_i) begin
                busy <= 1'b0;
                if (cmd_o == CMD_INIT) begin
                    reset_complete_o <= 1'b1;
                    state <= LS_RUN;
                end else if (cmd_o == CMD_SWEEP) begin
                    if (quit) begin
                        reset_complete_o <= 1'b0;
                        state <= LS_RESET;
                    end else if (loop_state_req_i != LS_RUN) begin
                        state <= loop_state_e'(loop_state_req_i); // Stop and pause land here.
                    end
                end
            end else if (!busy) begin
                case (state)
                    LS_RESET: begin
                        if (loop_enable_i) begin
                            cmd_o <= CMD_INIT;
                            cmd_start_o <= 1'b1;
                            busy <= 1'b1;
                        end
                    end
                    LS_RUN: begin
                        cmd_o <= CMD_SWEEP;          // Sweeps run back to back.
                        cmd_start_o <= 1'b1;
                        busy <= 1'b1;
                    end
                    default: begin
                        if (quit) begin
                            reset_complete_o <= 1'b0;
                            state <= LS_RESET;
                        end else if (upd_accept) begin
                            cmd_o <= CMD_UPDATE;
                            cmd_start_o <= 1'b1;
                            busy <= 1'b1;
                        end else if (loop_state_req_i != state) begin
                            state <= loop_state_e'(loop_state_req_i);
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* hdl/servo_execute.sv */
`timescale 1ns/10ps

module servo_execute
    import trig_loop_pkg::*;
#(
    parameter int NUM_CHAN = 64,
    localparam int IDX_W = $clog2(NUM_CHAN)
) (
    input  logic                wb_clk,
    input  logic                rst_n_i,
    input  loop_cmd_e           cmd_i,
    input  logic                cmd_start_i,
    input  logic [WB_DAT_W-1:0] target_rate_i,
    input  logic [15:0]         target_delta_i,
    input  logic                trig_count_done_i,
    input  logic                bus_done_i,
    input  logic [WB_DAT_W-1:0] bus_rdata_i,
    input  logic [THRESH_W-1:0] act_rdata_i,
    input  logic [THRESH_W-1:0] pend_rdata_i,
    output logic                cmd_done_o,
    output logic                bus_req_o,
    output logic                bus_we_o,
    output logic [WB_ADR_W-1:0] bus_adr_o,
    output logic [WB_DAT_W-1:0] bus_wdata_o,
    output logic [IDX_W-1:0]    rd_idx_o,
    output logic                act_we_o,
    output logic [THRESH_W-1:0] act_wdata_o,
    output logic                scal_we_o,
    output logic [WB_DAT_W-1:0] scal_wdata_o
);

    servo_op_e           op;
    logic [IDX_W-1:0]    chan;
    logic [THRESH_W-1:0] wr_val;    // Threshold for the next bus write.
    logic [THRESH_W-1:0] step_val;
    logic [WB_DAT_W:0]   win_hi;
    logic [WB_DAT_W-1:0] win_lo;
    logic                last_chan;

    assign last_chan = chan == IDX_W'(NUM_CHAN - 1);
    assign win_hi = {1'b0, target_rate_i} + (WB_DAT_W + 1)'(target_delta_i);
    assign win_lo = (target_rate_i > WB_DAT_W'(target_delta_i)) ?
                    target_rate_i - WB_DAT_W'(target_delta_i) : '0;

    always_comb begin
        step_val = act_rdata_i;
        if ({1'b0, bus_rdata_i} > win_hi) begin
            if (act_rdata_i != THRESH_MAX) step_val = act_rdata_i + 1'b1;
        end else if (bus_rdata_i < win_lo) begin
            if (act_rdata_i != '0) step_val = act_rdata_i - 1'b1;
        end
    end

    assign rd_idx_o = chan;
    assign bus_req_o = op inside {OP_INIT_WRITE, OP_START_COUNT, OP_READ_SCALER,
                                  OP_WRITE_THRESH, OP_UPDATE_WRITE};
    assign bus_we_o = op != OP_READ_SCALER;
    assign act_we_o = bus_done_i && op inside {OP_INIT_WRITE, OP_WRITE_THRESH, OP_UPDATE_WRITE};
    assign act_wdata_o = wr_val;
    assign scal_we_o = bus_done_i && op == OP_READ_SCALER;
    assign scal_wdata_o = bus_rdata_i;

    always_comb begin
        case (op)
            OP_START_COUNT: begin
                bus_adr_o = COUNT_CTRL_ADR;
                bus_wdata_o = WB_DAT_W'(1);
            end
            OP_READ_SCALER: begin
                bus_adr_o = SCAL_BASE + WB_ADR_W'(chan);
                bus_wdata_o = '0;
            end
            default: begin
                bus_adr_o = THRESH_BASE + WB_ADR_W'(chan);
                bus_wdata_o = WB_DAT_W'(wr_val);
            end
        endcase
    end

    always_ff @(posedge wb_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op <= OP_IDLE;
            chan <= '0;
            cmd_done_o <= 1'b0;
        end else begin
            cmd_done_o <= 1'b0;
            case (op)
                OP_IDLE: begin
                    if (cmd_start_i) begin
                        chan <= '0;
                        case (cmd_i)
                            CMD_INIT:   op <= OP_INIT_WRITE;
                            CMD_SWEEP:  op <= OP_START_COUNT;
                            CMD_UPDATE: op <= OP_UPDATE_READ;
                            default:    cmd_done_o <= 1'b1;
                        endcase
                    end
                end
                OP_START_COUNT: if (bus_done_i) op <= OP_WAIT_COUNT;
                OP_WAIT_COUNT:  if (trig_count_done_i) op <= OP_READ_SCALER;
                OP_READ_SCALER: if (bus_done_i) op <= OP_WRITE_THRESH;
                OP_UPDATE_READ: op <= OP_UPDATE_WRITE;
                default: begin
                    if (bus_done_i) begin
                        if (last_chan) begin
                            op <= OP_IDLE;
                            cmd_done_o <= 1'b1;
                        end else begin
                            chan <= chan + 1'b1;
                            if (op == OP_WRITE_THRESH) op <= OP_READ_SCALER;
                            if (op == OP_UPDATE_WRITE) op <= OP_UPDATE_READ;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge wb_clk) begin
        if (op == OP_IDLE && cmd_start_i) begin
            wr_val <= DEFAULT_THRESH;
        end else if (op == OP_READ_SCALER && bus_done_i) begin
            wr_val <= step_val;              // One step toward the rate window.
        end else if (op == OP_UPDATE_READ) begin
            wr_val <= pend_rdata_i;
        end
    end

endmodule

/* hdl/wb_bus_master.sv */
`timescale 1ns/10ps

module wb_bus_master
    import trig_loop_pkg::*;
(
    input  logic                wb_clk,
    input  logic                rst_n_i,
    input  logic                bus_req_i,
    input  logic                bus_we_i,
    input  logic [WB_ADR_W-1:0] bus_adr_i,
    input  logic [WB_DAT_W-1:0] bus_wdata_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    input  logic                wb_ack_i,
    output logic                bus_done_o,
    output logic [WB_DAT_W-1:0] bus_rdata_o,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    output logic [WB_DAT_W-1:0] wb_dat_o
);

    logic cyc_q;
    logic start;

    // The done cycle doubles as the idle gap, while the requester still holds its request.
    assign start = !cyc_q && bus_req_i && !bus_done_o;
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;

    always_ff @(posedge wb_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cyc_q <= 1'b0;
            bus_done_o <= 1'b0;
        end else begin
            bus_done_o <= 1'b0;
            if (cyc_q) begin
                if (wb_ack_i) begin
                    cyc_q <= 1'b0;
                    bus_done_o <= 1'b1;
                end
            end else if (start) begin
                cyc_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk) begin
        if (start) begin
            wb_we_o <= bus_we_i;             // Held until the ack is seen.
            wb_adr_o <= bus_adr_i;
            wb_dat_o <= bus_wdata_i;
        end
        if (cyc_q && wb_ack_i) begin
            bus_rdata_o <= wb_dat_i;
        end
    end

endmodule

/* hdl/thresh_scaler_store.sv */
`timescale 1ns/10ps

module thresh_scaler_store
    import trig_loop_pkg::*;
#(
    parameter int NUM_CHAN = 64,
    localparam int IDX_W = $clog2(NUM_CHAN)
) (
    input  logic                wb_clk,
    input  logic                rst_n_i,
    input  logic                act_we_i,
    input  logic [THRESH_W-1:0] act_wdata_i,
    input  logic [IDX_W-1:0]    rd_idx_i,
    input  logic                scal_we_i,
    input  logic [WB_DAT_W-1:0] scal_wdata_i,
    input  logic                pend_we_i,
    input  logic [IDX_W-1:0]    pend_idx_i,
    input  logic [THRESH_W-1:0] pend_dat_i,
    input  logic [IDX_W-1:0]    thresh_idx_i,
    input  logic [IDX_W-1:0]    scal_idx_i,
    output logic [THRESH_W-1:0] act_rdata_o,
    output logic [THRESH_W-1:0] pend_rdata_o,
    output logic [THRESH_W-1:0] thresh_dat_o,
    output logic [WB_DAT_W-1:0] scal_dat_o
);

    logic [THRESH_W-1:0] act_mem  [NUM_CHAN];
    logic [THRESH_W-1:0] pend_mem [NUM_CHAN];
    logic [WB_DAT_W-1:0] scal_mem [NUM_CHAN];

    // The sequencer reads and writes at the same channel index.
    assign act_rdata_o = act_mem[rd_idx_i];
    assign pend_rdata_o = pend_mem[rd_idx_i];

    always_ff @(posedge wb_clk) begin
        if (act_we_i) begin
            act_mem[rd_idx_i] <= act_wdata_i;
        end
        if (scal_we_i) begin
            scal_mem[rd_idx_i] <= scal_wdata_i;
        end
        thresh_dat_o <= act_mem[thresh_idx_i]; // User ports lag the index by one cycle.
        scal_dat_o <= scal_mem[scal_idx_i];
    end

    // Staged values start at the default, so an update without staging is harmless.
    always_ff @(posedge wb_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                pend_mem[i] <= DEFAULT_THRESH;
            end
        end else if (pend_we_i) begin
            pend_mem[pend_idx_i] <= pend_dat_i;
        end
    end

endmodule

/* hdl/trig_loop_top.sv */
`timescale 1ns/10ps

module trig_loop_top
    import trig_loop_pkg::*;
#(
    parameter int NUM_CHAN = 64,
    localparam int IDX_W = $clog2(NUM_CHAN)
) (
    input  logic                wb_clk,
    input  logic                rst_n_i,
    input  logic                loop_enable_i,
    input  logic [1:0]          loop_state_req_i,
    output loop_state_e         loop_state_o,
    output logic                reset_complete_o,
    input  logic [WB_DAT_W-1:0] target_rate_i,
    input  logic [15:0]         target_delta_i,
    input  logic                thresh_wr_i,
    input  logic                thresh_upd_i,
    input  logic [IDX_W-1:0]    thresh_idx_i,
    input  logic [THRESH_W-1:0] thresh_dat_i,
    output logic                thresh_ack_o,
    output logic [THRESH_W-1:0] thresh_dat_o,
    input  logic [IDX_W-1:0]    scal_idx_i,
    output logic [WB_DAT_W-1:0] scal_dat_o,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [WB_ADR_W-1:0] wb_adr_o,
    output logic [WB_DAT_W-1:0] wb_dat_o,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    input  logic                wb_ack_i,
    input  logic                trig_count_done_i
);

    loop_cmd_e           cmd;
    logic                cmd_start;
    logic                cmd_done;
    logic                pend_we;
    logic [IDX_W-1:0]    pend_idx;
    logic [THRESH_W-1:0] pend_dat;
    logic                bus_req;
    logic                bus_we;
    logic [WB_ADR_W-1:0] bus_adr;
    logic [WB_DAT_W-1:0] bus_wdata;
    logic                bus_done;
    logic [WB_DAT_W-1:0] bus_rdata;
    logic [IDX_W-1:0]    rd_idx;
    logic                act_we;
    logic [THRESH_W-1:0] act_wdata;
    logic [THRESH_W-1:0] act_rdata;
    logic [THRESH_W-1:0] pend_rdata;
    logic                scal_we;
    logic [WB_DAT_W-1:0] scal_wdata;

    loop_state_decode #(.NUM_CHAN(NUM_CHAN)) decode_i (
        .wb_clk(wb_clk), .rst_n_i(rst_n_i),
        .loop_enable_i(loop_enable_i), .loop_state_req_i(loop_state_req_i),
        .thresh_wr_i(thresh_wr_i), .thresh_upd_i(thresh_upd_i),
        .thresh_idx_i(thresh_idx_i), .thresh_dat_i(thresh_dat_i),
        .cmd_done_i(cmd_done), .loop_state_o(loop_state_o),
        .reset_complete_o(reset_complete_o), .thresh_ack_o(thresh_ack_o),
        .cmd_o(cmd), .cmd_start_o(cmd_start),
        .pend_we_o(pend_we), .pend_idx_o(pend_idx), .pend_dat_o(pend_dat)
    );

    servo_execute #(.NUM_CHAN(NUM_CHAN)) execute_i (
        .wb_clk(wb_clk), .rst_n_i(rst_n_i),
        .cmd_i(cmd), .cmd_start_i(cmd_start),
        .target_rate_i(target_rate_i), .target_delta_i(target_delta_i),
        .trig_count_done_i(trig_count_done_i),
        .bus_done_i(bus_done), .bus_rdata_i(bus_rdata),
        .act_rdata_i(act_rdata), .pend_rdata_i(pend_rdata),
        .cmd_done_o(cmd_done), .bus_req_o(bus_req), .bus_we_o(bus_we),
        .bus_adr_o(bus_adr), .bus_wdata_o(bus_wdata), .rd_idx_o(rd_idx),
        .act_we_o(act_we), .act_wdata_o(act_wdata),
        .scal_we_o(scal_we), .scal_wdata_o(scal_wdata)
    );

    wb_bus_master master_i (
        .wb_clk(wb_clk), .rst_n_i(rst_n_i),
        .bus_req_i(bus_req), .bus_we_i(bus_we), .bus_adr_i(bus_adr), .bus_wdata_i(bus_wdata),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .bus_done_o(bus_done), .bus_rdata_o(bus_rdata),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o)
    );

    thresh_scaler_store #(.NUM_CHAN(NUM_CHAN)) store_i (
        .wb_clk(wb_clk), .rst_n_i(rst_n_i),
        .act_we_i(act_we), .act_wdata_i(act_wdata), .rd_idx_i(rd_idx),
        .scal_we_i(scal_we), .scal_wdata_i(scal_wdata),
        .pend_we_i(pend_we), .pend_idx_i(pend_idx), .pend_dat_i(pend_dat),
        .thresh_idx_i(thresh_idx_i), .scal_idx_i(scal_idx_i),
        .act_rdata_o(act_rdata), .pend_rdata_o(pend_rdata),
        .thresh_dat_o(thresh_dat_o), .scal_dat_o(scal_dat_o)
    );

endmodule

/* bench/wb_scaler_model.sv */
`timescale 1ns/10ps

module wb_scaler_model
    import trig_loop_pkg::*;
#(
    parameter int NUM_CHAN = 8,
    parameter int COUNT_CYC = 20
) (
    input  logic                wb_clk,
    input  logic                rst_n_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [WB_DAT_W-1:0] wb_dat_i,
    input  logic [WB_DAT_W-1:0] rate_i [NUM_CHAN],
    output logic [WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack_o,
    output logic                count_done_o
);

    logic [THRESH_W-1:0] last_thresh [NUM_CHAN];
    int                  wr_count    [NUM_CHAN];
    int                  count_left;
    logic                take;
    logic [WB_ADR_W-1:0] thr_ofs;
    logic [WB_ADR_W-1:0] scal_ofs;

    assign take = wb_cyc_i && wb_stb_i && !wb_ack_o; // Each strobed cycle is acked a cycle later.
    assign thr_ofs = wb_adr_i - THRESH_BASE;
    assign scal_ofs = wb_adr_i - SCAL_BASE;

    always_ff @(posedge wb_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            count_done_o <= 1'b0;
            count_left <= 0;
            for (int i = 0; i < NUM_CHAN; i++) begin
                last_thresh[i] <= '0;
                wr_count[i] <= 0;
            end
        end else begin
            wb_ack_o <= take;
            if (count_left == 1) begin
                count_done_o <= 1'b1;
            end
            if (count_left != 0) begin
                count_left <= count_left - 1;
            end
            if (take && wb_we_i) begin
                if (wb_adr_i == COUNT_CTRL_ADR && wb_dat_i[0]) begin
                    count_left <= COUNT_CYC;         // A new count clears the old done flag.
                    count_done_o <= 1'b0;
                end else if (thr_ofs < NUM_CHAN) begin
                    last_thresh[thr_ofs] <= wb_dat_i[THRESH_W-1:0];
                    wr_count[thr_ofs] <= wr_count[thr_ofs] + 1;
                end
            end else if (take) begin
                wb_dat_o <= (scal_ofs < NUM_CHAN) ? rate_i[scal_ofs] : '0;
            end
        end
    end

endmodule

/* bench/trig_loop_assertions.sv */
`timescale 1ns/10ps

module trig_loop_assertions
    import trig_loop_pkg::*;
(
    input logic                wb_clk,
    input logic                rst_n_i,
    input logic                wb_cyc_o,
    input logic                wb_stb_o,
    input logic                wb_we_o,
    input logic [WB_ADR_W-1:0] wb_adr_o,
    input logic [WB_DAT_W-1:0] wb_dat_o,
    input logic                wb_ack_i,
    input logic                thresh_ack_o,
    input logic                reset_complete_o,
    input loop_state_e         loop_state_o,
    input loop_cmd_e           cmd_i
);

    int fail_count = 0;

    reset_quiet: assert property (@(posedge wb_clk) !rst_n_i && $past(!rst_n_i) |->
        !wb_cyc_o && !wb_stb_o && !thresh_ack_o && !reset_complete_o && loop_state_o == LS_RESET)
    else begin
        $error("Outputs not at their reset values while reset is held.");
        fail_count++;
    end

    stb_with_cyc: assert property (@(posedge wb_clk) disable iff (!rst_n_i) wb_stb_o |-> wb_cyc_o)
    else begin
        $error("Strobe raised without cycle.");
        fail_count++;
    end

    hold_until_ack: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=>
        wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o) && $stable(wb_dat_o))
    else begin
        $error("Address, direction or data moved before the ack.");
        fail_count++;
    end

    drop_after_ack: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        wb_cyc_o && wb_ack_i |=> !wb_cyc_o)
    else begin
        $error("Cycle still open after the ack.");
        fail_count++;
    end

    // Only a staged update may use the bus once the loop has stopped.
    stop_quiet: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        wb_cyc_o && loop_state_o == LS_STOP |-> cmd_i == CMD_UPDATE)
    else begin
        $error("Bus cycle in the stop state outside an update.");
        fail_count++;
    end

    pause_quiet: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        loop_state_o == LS_PAUSE |-> !wb_cyc_o)
    else begin
        $error("Bus cycle in the pause state.");
        fail_count++;
    end

endmodule

bind trig_loop_top trig_loop_assertions assert_i (
    .wb_clk(wb_clk), .rst_n_i(rst_n_i), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o),
    .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_ack_i(wb_ack_i),
    .thresh_ack_o(thresh_ack_o), .reset_complete_o(reset_complete_o),
    .loop_state_o(loop_state_o), .cmd_i(cmd)
);

/* bench/trig_loop_tb.sv */
`timescale 1ns/10ps

module trig_loop_tb
    import trig_loop_pkg::*;
();

    localparam int NUM_CHAN  = 8;
    localparam int IDX_W     = $clog2(NUM_CHAN);
    localparam int COUNT_CYC = 20;
    localparam int BUS_CYC   = 5;                   // One bus transaction with its idle gap.
    localparam int INIT_CYC  = 16 + NUM_CHAN * BUS_CYC + 4;
    localparam int SWEEP_CYC = BUS_CYC + COUNT_CYC + 2 * NUM_CHAN * BUS_CYC + 4;
    localparam int UPD_CYC   = NUM_CHAN * (BUS_CYC + 1) + 4;
    localparam int LIMIT     = 4 * (INIT_CYC + 6 * SWEEP_CYC + UPD_CYC);

    logic                wb_clk;
    logic                rst_n_i;
    logic                loop_enable_i;
    logic [1:0]          loop_state_req_i;
    loop_state_e         loop_state_o;
    logic                reset_complete_o;
    logic [WB_DAT_W-1:0] target_rate_i;
    logic [15:0]         target_delta_i;
    logic                thresh_wr_i;
    logic                thresh_upd_i;
    logic                thresh_ack_o;
    logic [IDX_W-1:0]    thresh_idx_i;
    logic [IDX_W-1:0]    scal_idx_i;
    logic [THRESH_W-1:0] thresh_dat_i;
    logic [THRESH_W-1:0] thresh_dat_o;
    logic [WB_DAT_W-1:0] scal_dat_o;
    logic                wb_cyc_o;
    logic                wb_stb_o;
    logic                wb_we_o;
    logic [WB_ADR_W-1:0] wb_adr_o;
    logic [WB_DAT_W-1:0] wb_dat_o;
    logic [WB_DAT_W-1:0] wb_dat_i;
    logic                wb_ack_i;
    logic                trig_count_done_i;
    logic [WB_DAT_W-1:0] rate    [NUM_CHAN];
    logic [THRESH_W-1:0] exp_thr [NUM_CHAN];
    logic [THRESH_W-1:0] pend    [NUM_CHAN];
    int                  cat     [NUM_CHAN];    // 0 below, 1 inside, 2 above the window.
    logic [15:0]         lfsr;
    int                  cycles;
    int                  errors;
    int                  checks;
    int                  seen_writes;

    trig_loop_top #(.NUM_CHAN(NUM_CHAN)) trig_loop_top_i (.*);

    wb_scaler_model #(.NUM_CHAN(NUM_CHAN), .COUNT_CYC(COUNT_CYC)) scaler_i (
        .wb_clk(wb_clk), .rst_n_i(rst_n_i), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
        .wb_we_i(wb_we_o), .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o), .rate_i(rate),
        .wb_dat_o(wb_dat_i), .wb_ack_o(wb_ack_i), .count_done_o(trig_count_done_i)
    );

    initial begin
        wb_clk = 1'b0;
        forever #50 wb_clk = ~wb_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge wb_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11.
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val = {val[30:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [THRESH_W-1:0] next_thresh(input logic [THRESH_W-1:0] thr,
                                                         input logic [31:0] r);
        longint hi;
        longint lo;
        hi = longint'(target_rate_i) + longint'(target_delta_i);
        lo = longint'(target_rate_i) - longint'(target_delta_i); // Below zero acts as zero.
        if (longint'(r) > hi) begin
            return (thr == THRESH_MAX) ? thr : thr + 1'b1;
        end
        if (longint'(r) < lo) begin
            return (thr == '0) ? thr : thr - 1'b1;
        end
        return thr;
    endfunction

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
                                input string what);
        checks++;
        assert (got === want)
        else begin
            errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic wait_sweep();
        while (scaler_i.wr_count[NUM_CHAN-1] == seen_writes) @(negedge wb_clk);
    endtask

    task automatic wait_state(input loop_state_e s);
        while (loop_state_o != s) @(negedge wb_clk);
    endtask

    // Steps the expected thresholds once per finished sweep, then compares the bus writes.
    task automatic check_thresholds(input string what);
        while (seen_writes < scaler_i.wr_count[NUM_CHAN-1]) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                exp_thr[i] = next_thresh(exp_thr[i], rate[i]);
            end
            seen_writes++;
        end
        for (int i = 0; i < NUM_CHAN; i++) begin
            expect_equal(scaler_i.last_thresh[i], exp_thr[i], $sformatf("%s ch%0d", what, i));
        end
    endtask

    task automatic check_readback(input string what);
        for (int i = 0; i < NUM_CHAN; i++) begin
            thresh_idx_i = IDX_W'(i);
            @(negedge wb_clk);
            expect_equal(thresh_dat_o, exp_thr[i], $sformatf("%s ch%0d", what, i));
        end
    endtask

    // Every sweep reads the model rates, so the stored scalers must equal them.
    task automatic scaler_readback(input string what);
        for (int i = 0; i < NUM_CHAN; i++) begin
            scal_idx_i = IDX_W'(i);
            @(negedge wb_clk);
            expect_equal(scal_dat_o, rate[i], $sformatf("%s ch%0d", what, i));
        end
    endtask

    task automatic stage_write(input int idx, input logic [THRESH_W-1:0] val);
        thresh_wr_i = 1'b1;
        thresh_idx_i = IDX_W'(idx);
        thresh_dat_i = val;
        @(negedge wb_clk);
        while (!thresh_ack_o) @(negedge wb_clk);
        thresh_wr_i = 1'b0;
        @(negedge wb_clk);
    endtask

    task automatic report_test(input string name, input int mark);
        $display("Test %s done, %0d errors", name, errors - mark);
    endtask

    initial begin
        logic [31:0] r;
        int          mark;
        int          asrt;
        rst_n_i = 1'b0;
        loop_enable_i = 1'b0;
        loop_state_req_i = LS_RUN;
        target_rate_i = 32'd5000;
        target_delta_i = 16'd100;
        thresh_wr_i = 1'b0;
        thresh_upd_i = 1'b0;
        thresh_idx_i = '0;
        thresh_dat_i = '0;
        scal_idx_i = '0;
        errors = 0;
        checks = 0;
        seen_writes = 0;
        lfsr = 16'd47220;
        for (int i = 0; i < NUM_CHAN; i++) begin
            draw_bits(2, r);
            cat[i] = (r == 3) ? i % 3 : int'(r);
            draw_bits(7, r);
            case (cat[i])
                0:       rate[i] = target_rate_i - target_delta_i - 1 - r;
                1:       rate[i] = target_rate_i - target_delta_i + r;
                default: rate[i] = target_rate_i + target_delta_i + 1 + r;
            endcase
            exp_thr[i] = DEFAULT_THRESH;
        end
        repeat (16) @(negedge wb_clk);
        rst_n_i = 1'b1;
        @(negedge wb_clk);

        mark = errors;
        expect_equal(wb_cyc_o, 0, "wb_cyc_o after reset");
        expect_equal(reset_complete_o, 0, "reset_complete_o after reset");
        expect_equal(thresh_ack_o, 0, "thresh_ack_o after reset");
        expect_equal(loop_state_o, LS_RESET, "loop_state_o after reset");
        loop_enable_i = 1'b1;
        while (!reset_complete_o) @(negedge wb_clk);
        expect_equal(loop_state_o, LS_RUN, "loop_state_o after init");
        for (int i = 0; i < NUM_CHAN; i++) begin
            expect_equal(scaler_i.last_thresh[i], DEFAULT_THRESH, $sformatf("init ch%0d", i));
            expect_equal(scaler_i.wr_count[i], 1, $sformatf("init writes ch%0d", i));
        end
        seen_writes = 1;
        report_test("reset and init", mark);

        mark = errors;
        repeat (2) begin
            wait_sweep();
            check_thresholds("sweep");
        end
        report_test("servo step", mark);

        mark = errors;
        loop_state_req_i = LS_PAUSE;
        wait_state(LS_PAUSE);
        check_thresholds("pause arrival");
        check_readback("pause readback");
        scaler_readback("pause scalers");
        repeat (20) @(negedge wb_clk);
        expect_equal(scaler_i.wr_count[NUM_CHAN-1], seen_writes, "writes while paused");
        loop_state_req_i = LS_RUN;
        wait_state(LS_RUN);
        wait_sweep();
        loop_state_req_i = LS_STOP;
        check_thresholds("resumed sweep");
        wait_state(LS_STOP);
        check_thresholds("stop arrival");
        check_readback("stop readback");
        report_test("state control", mark);

        mark = errors;
        for (int i = 0; i < NUM_CHAN; i++) begin
            draw_bits(THRESH_W, r);
            pend[i] = (cat[i] == 0) ? '0 : (cat[i] == 2) ? THRESH_MAX : r[THRESH_W-1:0];
            stage_write(i, pend[i]);
        end
        check_readback("staged readback");
        loop_state_req_i = LS_PAUSE;
        wait_state(LS_PAUSE);
        thresh_upd_i = 1'b1;
        repeat (10) begin
            @(negedge wb_clk);
            expect_equal(thresh_ack_o, 0, "update ack in pause");
        end
        loop_state_req_i = LS_STOP;
        while (!thresh_ack_o) @(negedge wb_clk);
        thresh_upd_i = 1'b0;
        expect_equal(loop_state_o, LS_STOP, "loop_state_o at update ack");
        for (int i = 0; i < NUM_CHAN; i++) begin
            expect_equal(scaler_i.last_thresh[i], pend[i], $sformatf("update ch%0d", i));
            expect_equal(scaler_i.wr_count[i], seen_writes + 1,
                         $sformatf("update writes ch%0d", i));
            exp_thr[i] = pend[i];
        end
        seen_writes++;
        check_readback("updated readback");
        loop_state_req_i = LS_RUN;
        repeat (2) begin
            wait_sweep();
            check_thresholds("sweep after update");
        end
        report_test("staged update", mark);

        asrt = trig_loop_top_i.assert_i.fail_count;
        $display("Test bus protocol done, %0d assertion failures", asrt);
        $display("Checks: %0d run, %0d failed, %0d assertion failures", checks, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/trig_loop_pkg.sv
hdl/loop_state_decode.sv
hdl/servo_execute.sv
hdl/wb_bus_master.sv
hdl/thresh_scaler_store.sv
hdl/trig_loop_top.sv
bench/wb_scaler_model.sv
bench/trig_loop_assertions.sv
bench/trig_loop_tb.sv
